/* design/fetch_params.svh */
`ifndef FETCH_PARAMS_SVH
`define FETCH_PARAMS_SVH

// Instruction and address width.
`define WORD_SIZE 32

// Cache line geometry.
`define LINE_WORDS 4
`define LINE_SIZE 128
`define ICACHE_LINES 16

// Backing instruction memory.
`define IMEM_WORDS 1024
`define MEM_LATENCY 3

// Reset PC and the canonical NOP, addi x0,x0,0.
`define PC_INITIAL 32'h0000_0000
`define NOP_INSTR 32'h0000_0013

`endif

/* design/fetchPkg.sv */
package fetchPkg;

   // Refill machine of the instruction cache.
   typedef enum logic [1:0] {
      cacheIdle    = 2'd0,
      cacheRequest = 2'd1,
      cacheFill    = 2'd2
   } cacheState;

   // Arbiter grant state.
   // Busy states lock the memory to one requester until ready.
   typedef enum logic [1:0] {
      arbFree   = 2'd0,
      arbCache  = 2'd1,
      arbLoader = 2'd2
   } arbState;

   // Current owner of the instruction memory.
   typedef enum logic {
      ownerCache  = 1'b0,
      ownerLoader = 1'b1
   } memOwner;

endpackage

/* design/memBus.sv */
`timescale 1ns/10ps
`include "fetch_params.svh"

// One memory transaction between a requester and the memory side.
// The requester holds req and the request fields until ready.
interface memBus;

   logic                  req;
   logic                  write;
   // Word address, not byte address.
   logic [`WORD_SIZE-1:0] addr;
   logic [`WORD_SIZE-1:0] wdata;
   logic [`LINE_SIZE-1:0] rline;
   // Single-cycle completion pulse.
   logic                  ready;

   modport requester (
      output req, write, addr, wdata,
      input  rline, ready
   );

   modport memory (
      input  req, write, addr, wdata,
      output rline, ready
   );

endinterface

/* design/programCounter.sv */
`timescale 1ns/10ps
`include "fetch_params.svh"

module programCounter (
   input  logic                  clk,
   input  logic                  rst,
   input  logic                  pcSrc,
   input  logic [`WORD_SIZE-1:0] pcTarget,
   input  logic                  hold,
   output logic [`WORD_SIZE-1:0] pc,
   output logic [`WORD_SIZE-1:0] pcPlus4
);

   localparam logic [`WORD_SIZE-1:0] instrBytes = 4;

   logic [`WORD_SIZE-1:0] pcNext;

   // Sequential address.
   assign pcPlus4 = pc + instrBytes;

   // Redirect from execute wins over the sequential path.
   assign pcNext = pcSrc ? pcTarget : pcPlus4;

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         pc <= `PC_INITIAL;
      end else if (!hold) begin
         pc <= pcNext;
      end
   end

endmodule

/* design/instructionCache.sv */
`timescale 1ns/10ps
`include "fetch_params.svh"

module instructionCache (
   input  logic                  clk,
   input  logic                  rst,
   input  logic [`WORD_SIZE-1:0] pc,
   output logic [`WORD_SIZE-1:0] instr,
   output logic                  cacheStall,
   memBus.requester              mem
);

   localparam int offsetBits = $clog2(`LINE_WORDS);
   localparam int indexBits  = $clog2(`ICACHE_LINES);
   // Two low PC bits select the byte and are dropped.
   localparam int tagBits    = `WORD_SIZE - indexBits - offsetBits - 2;

   fetchPkg::cacheState state;
   fetchPkg::cacheState nextState;

   logic [`ICACHE_LINES-1:0] validBits;
   logic [tagBits-1:0]       tagArr  [`ICACHE_LINES];
   logic [`LINE_SIZE-1:0]    lineArr [`ICACHE_LINES];

   logic [offsetBits-1:0] offset;
   logic [indexBits-1:0]  index;
   logic [tagBits-1:0]    tag;
   logic                  hit;
   logic                  fillNow;

   // Line being refilled.
   logic [indexBits-1:0] refillIndex;
   logic [tagBits-1:0]   refillTag;

   // PC split into tag, index and word offset.
   assign offset = pc[offsetBits+1:2];
   assign index  = pc[indexBits+offsetBits+1:offsetBits+2];
   assign tag    = pc[`WORD_SIZE-1:indexBits+offsetBits+2];

   assign hit   = validBits[index] && (tagArr[index] == tag);
   assign instr = lineArr[index][offset*`WORD_SIZE +: `WORD_SIZE];

   // Stall follows the miss directly, so it drops as soon as
   // the refilled line is in the arrays. Low during reset.
   assign cacheStall = !hit && !rst;

   assign fillNow = (state == fetchPkg::cacheRequest) && mem.ready;

   // Line reads only, at the aligned word address of the line.
   assign mem.req   = (state == fetchPkg::cacheRequest);
   assign mem.write = 1'b0;
   assign mem.wdata = '0;
   assign mem.addr  = {2'b00, refillTag, refillIndex, {offsetBits{1'b0}}};

   always_comb begin
      nextState = state;
      case (state)
         fetchPkg::cacheIdle: begin
            if (!hit) begin
               nextState = fetchPkg::cacheRequest;
            end
         end
         fetchPkg::cacheRequest: begin
            if (mem.ready) begin
               nextState = fetchPkg::cacheFill;
            end
         end
         // Request is down for one cycle before a new miss is taken.
         fetchPkg::cacheFill: begin
            nextState = fetchPkg::cacheIdle;
         end
         default: begin
            nextState = fetchPkg::cacheIdle;
         end
      endcase
   end

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         state     <= fetchPkg::cacheIdle;
         validBits <= '0;
      end else begin
         state <= nextState;
         if (fillNow) begin
            validBits[refillIndex] <= 1'b1;
         end
      end
   end

   always_ff @(posedge clk) begin
      // PC is held during the stall, so the miss address stays put.
      if (state == fetchPkg::cacheIdle && !hit) begin
         refillTag   <= tag;
         refillIndex <= index;
      end
      if (fillNow) begin
         tagArr[refillIndex]  <= refillTag;
         lineArr[refillIndex] <= mem.rline;
      end
   end

endmodule

/* design/programLoader.sv */
`timescale 1ns/10ps
`include "fetch_params.svh"

module programLoader (
   input  logic                  clk,
   input  logic                  rst,
   input  logic                  loadValid,
   // Byte address of a word-aligned instruction.
   input  logic [`WORD_SIZE-1:0] loadAddr,
   input  logic [`WORD_SIZE-1:0] loadData,
   output logic                  loadBusy,
   output logic                  loadDone,
   memBus.requester              mem
);

   logic                  pending;
   logic                  accept;
   logic [`WORD_SIZE-1:0] pendAddr;
   logic [`WORD_SIZE-1:0] pendData;

   // New writes are only taken when nothing is pending.
   assign accept   = loadValid && !pending;
   assign loadBusy = pending;

   assign mem.req   = pending;
   assign mem.write = 1'b1;
   assign mem.addr  = pendAddr;
   assign mem.wdata = pendData;

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         pending  <= 1'b0;
         loadDone <= 1'b0;
      end else begin
         loadDone <= pending && mem.ready;
         if (pending && mem.ready) begin
            pending <= 1'b0;
         end else if (accept) begin
            pending <= 1'b1;
         end
      end
   end

   // Bus addresses words.
   always_ff @(posedge clk) begin
      if (accept) begin
         pendAddr <= {2'b00, loadAddr[`WORD_SIZE-1:2]};
         pendData <= loadData;
      end
   end

endmodule

/* design/memArbiter.sv */
`timescale 1ns/10ps
`include "fetch_params.svh"

module memArbiter (
   input  logic     clk,
   input  logic     rst,
   memBus.memory    cacheSide,
   memBus.memory    loaderSide,
   memBus.requester memSide
);

   fetchPkg::arbState state;
   fetchPkg::arbState nextState;
   fetchPkg::memOwner owner;

   // Locked owner while busy, loader first when free.
   always_comb begin
      case (state)
         fetchPkg::arbCache:  owner = fetchPkg::ownerCache;
         fetchPkg::arbLoader: owner = fetchPkg::ownerLoader;
         default: begin
            owner = loaderSide.req ? fetchPkg::ownerLoader : fetchPkg::ownerCache;
         end
      endcase
   end

   always_comb begin
      if (owner == fetchPkg::ownerLoader) begin
         memSide.req   = loaderSide.req;
         memSide.write = loaderSide.write;
         memSide.addr  = loaderSide.addr;
         memSide.wdata = loaderSide.wdata;
      end else begin
         memSide.req   = cacheSide.req;
         memSide.write = cacheSide.write;
         memSide.addr  = cacheSide.addr;
         memSide.wdata = cacheSide.wdata;
      end
      // Responses go back to the owner only.
      cacheSide.ready  = memSide.ready && (owner == fetchPkg::ownerCache);
      cacheSide.rline  = (owner == fetchPkg::ownerCache) ? memSide.rline : '0;
      loaderSide.ready = memSide.ready && (owner == fetchPkg::ownerLoader);
      loaderSide.rline = (owner == fetchPkg::ownerLoader) ? memSide.rline : '0;
   end

   always_comb begin
      nextState = state;
      case (state)
         fetchPkg::arbFree: begin
            if (memSide.req) begin
               nextState = (owner == fetchPkg::ownerLoader) ? fetchPkg::arbLoader
                                                            : fetchPkg::arbCache;
            end
         end
         fetchPkg::arbCache, fetchPkg::arbLoader: begin
            if (memSide.ready) begin
               nextState = fetchPkg::arbFree;
            end
         end
         default: begin
            nextState = fetchPkg::arbFree;
         end
      endcase
   end

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         state <= fetchPkg::arbFree;
      end else begin
         state <= nextState;
      end
   end

endmodule

/* design/instructionMemory.sv */
`timescale 1ns/10ps
`include "fetch_params.svh"

module instructionMemory (
   input  logic  clk,
   input  logic  rst,
   memBus.memory bus
);

   localparam int addrBits   = $clog2(`IMEM_WORDS);
   localparam int offsetBits = $clog2(`LINE_WORDS);
   localparam int countBits  = $clog2(`MEM_LATENCY + 1);

   logic [`WORD_SIZE-1:0] words [`IMEM_WORDS];

   logic                  busy;
   logic [countBits-1:0]  count;
   logic                  accept;
   logic                  finish;

   // Request captured on acceptance.
   logic                  isWrite;
   logic [addrBits-1:0]   reqAddr;
   logic [`WORD_SIZE-1:0] reqData;

   logic [addrBits-1:0]   lineBase;
   logic [`LINE_SIZE-1:0] lineData;

   // Not taken during the ready cycle, while the requester still holds req.
   assign accept = bus.req && !busy && !bus.ready;
   assign finish = busy && (count == countBits'(1));

   // Aligned line, word 0 in the low bits.
   assign lineBase = {reqAddr[addrBits-1:offsetBits], {offsetBits{1'b0}}};

   always_comb begin
      for (int i = 0; i < `LINE_WORDS; i++) begin
         lineData[i*`WORD_SIZE +: `WORD_SIZE] = words[lineBase + addrBits'(i)];
      end
   end

   // Latency counter, ready comes MEM_LATENCY cycles after the request.
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         busy      <= 1'b0;
         count     <= '0;
         bus.ready <= 1'b0;
      end else begin
         bus.ready <= 1'b0;
         if (accept) begin
            busy  <= 1'b1;
            count <= countBits'(`MEM_LATENCY - 1);
         end else if (finish) begin
            busy      <= 1'b0;
            bus.ready <= 1'b1;
         end else if (busy) begin
            count <= count - 1'b1;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (accept) begin
         isWrite <= bus.write;
         reqAddr <= bus.addr[addrBits-1:0];
         reqData <= bus.wdata;
      end
      if (finish) begin
         if (isWrite) begin
            words[reqAddr] <= reqData;
         end else begin
            bus.rline <= lineData;
         end
      end
   end

endmodule

/* design/fetchUnit.sv */
`timescale 1ns/10ps
`include "fetch_params.svh"

module fetchUnit (
   input  logic                  clk,
   input  logic                  rst,
   input  logic                  pcSrc,
   input  logic [`WORD_SIZE-1:0] pcTarget,
   input  logic                  stallF,
   input  logic                  stallD,
   input  logic                  flushD,
   input  logic                  loadValid,
   input  logic [`WORD_SIZE-1:0] loadAddr,
   input  logic [`WORD_SIZE-1:0] loadData,
   output logic                  loadBusy,
   output logic                  loadDone,
   output logic [`WORD_SIZE-1:0] instrD,
   output logic [`WORD_SIZE-1:0] pcD,
   output logic [`WORD_SIZE-1:0] pcPlus4D,
   output logic                  cacheStall
);

   logic [`WORD_SIZE-1:0] pcF;
   logic [`WORD_SIZE-1:0] pcPlus4F;
   logic [`WORD_SIZE-1:0] instrF;
   logic                  hold;

   memBus cacheBus ();
   memBus loaderBus ();
   memBus memPort ();

   // Fetch stops for the hazard unit or a cache miss.
   assign hold = stallF | cacheStall;

   programCounter pcReg (
      .clk      (clk),
      .rst      (rst),
      .pcSrc    (pcSrc),
      .pcTarget (pcTarget),
      .hold     (hold),
      .pc       (pcF),
      .pcPlus4  (pcPlus4F)
   );

   instructionCache iCache (
      .clk        (clk),
      .rst        (rst),
      .pc         (pcF),
      .instr      (instrF),
      .cacheStall (cacheStall),
      .mem        (cacheBus.requester)
   );

   programLoader loader (
      .clk       (clk),
      .rst       (rst),
      .loadValid (loadValid),
      .loadAddr  (loadAddr),
      .loadData  (loadData),
      .loadBusy  (loadBusy),
      .loadDone  (loadDone),
      .mem       (loaderBus.requester)
   );

   memArbiter arbiter (
      .clk        (clk),
      .rst        (rst),
      .cacheSide  (cacheBus.memory),
      .loaderSide (loaderBus.memory),
      .memSide    (memPort.requester)
   );

   instructionMemory iMem (
      .clk (clk),
      .rst (rst),
      .bus (memPort.memory)
   );

   // Fetch-to-decode register.
   // Flush beats stall, stall beats advance.
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         instrD   <= '0;
         pcD      <= `PC_INITIAL;
         pcPlus4D <= `PC_INITIAL + 4;
      end else if (flushD) begin
         // bubble into decode, PC fields untouched
         instrD <= `NOP_INSTR;
      end else if (!stallD && !cacheStall) begin
         instrD   <= instrF;
         pcD      <= pcF;
         pcPlus4D <= pcPlus4F;
      end
   end

endmodule

/* tests/fetchUnitTb.sv */
`timescale 1ns/10ps
`include "fetch_params.svh"

module fetchUnitTb;

   localparam logic [31:0] seedValue = 32'ha593_88d9;
   // Program sits away from line 0, which the cold cache fills right after reset.
   localparam logic [`WORD_SIZE-1:0] progBase  = 32'h0000_0100;
   localparam int                    progWords = 32;
   localparam logic [`WORD_SIZE-1:0] extraAddr = 32'h0000_0300;
   localparam int fetchWords = 31;
   localparam int loadWords  = progWords + 1;
   localparam int watchdogCycles = 4 * (fetchWords + loadWords) * (`MEM_LATENCY + 10) + 200;

   logic                  clk = 1'b0;
   logic                  rst;
   logic                  pcSrc;
   logic [`WORD_SIZE-1:0] pcTarget;
   logic                  stallF;
   logic                  stallD;
   logic                  flushD;
   logic                  loadValid;
   logic [`WORD_SIZE-1:0] loadAddr;
   logic [`WORD_SIZE-1:0] loadData;
   logic                  loadBusy;
   logic                  loadDone;
   logic [`WORD_SIZE-1:0] instrD;
   logic [`WORD_SIZE-1:0] pcD;
   logic [`WORD_SIZE-1:0] pcPlus4D;
   logic                  cacheStall;

   // Words the loader has written, indexed by word address.
   logic [`WORD_SIZE-1:0] shadow [`IMEM_WORDS];

   fetchUnit fetchUnit_inst (
      .clk        (clk),
      .rst        (rst),
      .pcSrc      (pcSrc),
      .pcTarget   (pcTarget),
      .stallF     (stallF),
      .stallD     (stallD),
      .flushD     (flushD),
      .loadValid  (loadValid),
      .loadAddr   (loadAddr),
      .loadData   (loadData),
      .loadBusy   (loadBusy),
      .loadDone   (loadDone),
      .instrD     (instrD),
      .pcD        (pcD),
      .pcPlus4D   (pcPlus4D),
      .cacheStall (cacheStall)
   );

   always #5 clk = ~clk;

   initial begin
      repeat (watchdogCycles) @(posedge clk);
      $display("timeout: fetch tests still running after %0d cycles", watchdogCycles);
      $display("Test failed");
      $fatal(1, "watchdog expired");
   end

   function automatic logic [`WORD_SIZE-1:0] shadowWord(input logic [`WORD_SIZE-1:0] addr);
      return shadow[(addr >> 2) % `IMEM_WORDS];
   endfunction

   task automatic checkValue(input logic [`WORD_SIZE-1:0] actual,
                             input logic [`WORD_SIZE-1:0] expected, input string what);
      if (actual !== expected) begin
         $display("mismatch at %0t: %s, got %h, expected %h", $time, what, actual, expected);
         $display("Test failed");
         $fatal(1, "stopped at first mismatch");
      end
   endtask

   // Counts loadDone pulses until the pending write retires, plus one cycle.
   task automatic collectDone(output int pulses);
      pulses = 0;
      do begin
         @(negedge clk);
         if (loadDone) begin
            pulses++;
         end
      end while (loadBusy);
      @(negedge clk);
      if (loadDone) begin
         pulses++;
      end
   endtask

   task automatic loadWord(input logic [`WORD_SIZE-1:0] addr, input logic [`WORD_SIZE-1:0] data);
      int pulses;
      @(posedge clk);
      loadValid <= 1'b1;
      loadAddr  <= addr;
      loadData  <= data;
      @(posedge clk);
      loadValid <= 1'b0;
      @(negedge clk);
      checkValue(loadBusy, 1'b1, "loadBusy after accept");
      // Second write while busy, must be dropped.
      @(posedge clk);
      loadValid <= 1'b1;
      loadData  <= ~data;
      @(posedge clk);
      loadValid <= 1'b0;
      collectDone(pulses);
      checkValue(32'(pulses), 1, "loadDone pulses per write");
      shadow[(addr >> 2) % `IMEM_WORDS] = data;
   endtask

   // Holds pcSrc until fetch takes it, then drops it on that edge.
   task automatic redirectFetch(input logic [`WORD_SIZE-1:0] target);
      @(posedge clk);
      pcSrc    <= 1'b1;
      pcTarget <= target;
      stallF   <= 1'b0;
      do begin
         @(negedge clk);
      end while (cacheStall);
      @(posedge clk);
      pcSrc <= 1'b0;
   endtask

   // Follows decode advances from startPc with stalls and flush low.
   task automatic runFetch(input logic [`WORD_SIZE-1:0] startPc, input int count,
                           output int stallCycles);
      logic [`WORD_SIZE-1:0] expPc;
      logic                  advance;
      int                    seen;
      expPc = startPc;
      advance = 1'b0;
      seen = 0;
      stallCycles = 0;
      while (seen < count) begin
         @(negedge clk);
         if (advance) begin
            checkValue(pcD, expPc, "pcD after advance");
            checkValue(pcPlus4D, expPc + 4, "pcPlus4D after advance");
            checkValue(instrD, shadowWord(expPc), "instrD after advance");
            expPc = expPc + 4;
            seen++;
         end
         // PC and decode move together on the next edge unless the cache misses.
         advance = !cacheStall;
         if (cacheStall) begin
            stallCycles++;
         end
      end
   endtask

   // Reset values, sampled while rst is still high.
   task automatic checkReset();
      @(negedge clk);
      checkValue(instrD, '0, "instrD in reset");
      checkValue(pcD, `PC_INITIAL, "pcD in reset");
      checkValue(pcPlus4D, `PC_INITIAL + 4, "pcPlus4D in reset");
      checkValue(loadBusy, 1'b0, "loadBusy in reset");
      checkValue(loadDone, 1'b0, "loadDone in reset");
      checkValue(cacheStall, 1'b0, "cacheStall in reset");
   endtask

   task automatic loadProgram();
      for (int i = 0; i < progWords; i++) begin
         loadWord(progBase + 4 * i, $urandom());
      end
   endtask

   task automatic sequentialFetch();
      int stalls;
      redirectFetch(progBase);
      runFetch(progBase, 24, stalls);
      checkValue(32'(stalls > 0), 1, "misses raised cacheStall");
   endtask

   task automatic redirectHit();
      int stalls;
      redirectFetch(progBase + 8);
      runFetch(progBase + 8, 2, stalls);
      checkValue(32'(stalls), 0, "stall cycles on a cached line");
   endtask

   task automatic stallAndFlush();
      logic [`WORD_SIZE-1:0] heldInstr;
      logic [`WORD_SIZE-1:0] heldPc;
      logic [`WORD_SIZE-1:0] heldPcPlus4;
      @(posedge clk);
      stallF <= 1'b1;
      stallD <= 1'b1;
      @(negedge clk);
      heldInstr   = instrD;
      heldPc      = pcD;
      heldPcPlus4 = pcPlus4D;
      repeat (3) begin
         @(negedge clk);
         checkValue(instrD, heldInstr, "instrD under stallD");
         checkValue(pcD, heldPc, "pcD under stallD");
         checkValue(pcPlus4D, heldPcPlus4, "pcPlus4D under stallD");
      end
      // Flush together with stall.
      @(posedge clk);
      flushD <= 1'b1;
      @(posedge clk);
      flushD <= 1'b0;
      @(negedge clk);
      checkValue(instrD, `NOP_INSTR, "instrD after flush with stall");
      checkValue(pcD, heldPc, "pcD after flush with stall");
      checkValue(pcPlus4D, heldPcPlus4, "pcPlus4D after flush with stall");
      // Flush on its own.
      @(posedge clk);
      stallD <= 1'b0;
      flushD <= 1'b1;
      @(posedge clk);
      flushD <= 1'b0;
      @(negedge clk);
      checkValue(instrD, `NOP_INSTR, "instrD after flush");
      checkValue(pcD, heldPc, "pcD after flush");
      checkValue(pcPlus4D, heldPcPlus4, "pcPlus4D after flush");
   endtask

   task automatic loadDuringRefill();
      logic [`WORD_SIZE-1:0] extraData;
      int                    stalls;
      int                    pulses;
      extraData = $urandom();
      // Line 7 of the program has not been fetched yet.
      redirectFetch(progBase + 32'h70);
      @(posedge clk);
      loadValid <= 1'b1;
      loadAddr  <= extraAddr;
      loadData  <= extraData;
      @(posedge clk);
      loadValid <= 1'b0;
      fork
         runFetch(progBase + 32'h70, 4, stalls);
         collectDone(pulses);
      join
      checkValue(32'(pulses), 1, "loadDone pulses during refill");
      checkValue(32'(stalls > 0), 1, "refill raised cacheStall");
      shadow[(extraAddr >> 2) % `IMEM_WORDS] = extraData;
      // The write must have reached memory.
      redirectFetch(extraAddr);
      runFetch(extraAddr, 1, stalls);
   endtask

   initial begin
      void'($urandom(seedValue));
      rst       = 1'b1;
      pcSrc     = 1'b0;
      pcTarget  = '0;
      stallF    = 1'b1;
      stallD    = 1'b0;
      flushD    = 1'b0;
      loadValid = 1'b0;
      loadAddr  = '0;
      loadData  = '0;
      repeat (3) @(posedge clk);
      checkReset();
      @(posedge clk);
      rst <= 1'b0;
      loadProgram();
      sequentialFetch();
      redirectHit();
      stallAndFlush();
      loadDuringRefill();
      $display("Test completed successfully");
      $finish;
   end

endmodule

/* sim.f */
+incdir+design
design/fetchPkg.sv
design/memBus.sv
design/programCounter.sv
design/instructionCache.sv
design/programLoader.sv
design/memArbiter.sv
design/instructionMemory.sv
design/fetchUnit.sv
tests/fetchUnitTb.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing -Wno-fatal
TOP       = fetchUnitTb
FILELIST  = sim.f
OBJDIR    = obj_dir

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)
	./$(OBJDIR)/V$(TOP)

clean:
	rm -rf $(OBJDIR)
